/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= div_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* hw/div_collect.sv */
`default_nettype none
`timescale 1ns/1ns

`include "div_config.svh"

module div_collect (
  input  logic                                  clk,
  input  logic                                  arst_n,
  input  logic [`DIV_LANES-1:0]                 lane_done,
  input  logic [`DIV_LANES-1:0][`DIV_XLEN-1:0]  lane_result,
  input  logic [`DIV_LANES-1:0][`DIV_TAG_W-1:0] lane_tag_out,
  output logic [`DIV_LANES-1:0]                 lane_ack,
  input  logic                                  q_pop,
  output logic                                  q_valid,
  output logic [2:0]                            q_count,
  output logic [`DIV_TAG_W-1:0]                 q_tag,
  output logic [`DIV_XLEN-1:0]                  q_result
);

  localparam int PW = $clog2(`DIV_QDEPTH);

  logic [`DIV_TAG_W-1:0] tag_mem [`DIV_QDEPTH];
  logic [`DIV_XLEN-1:0]  res_mem [`DIV_QDEPTH];
  logic [PW-1:0]         wr_ptr;
  logic [PW-1:0]         rd_ptr;
  logic [2:0]            count_q;
  logic                  full;
  logic                  push;
  logic [`DIV_TAG_W-1:0] pick_tag;
  logic [`DIV_XLEN-1:0]  pick_res;

  assign full = (count_q == 3'(`DIV_QDEPTH));

  // Fixed priority, lane 0 first, nothing taken while full
  assign lane_ack = full ? '0 : (lane_done & -lane_done);
  assign push     = |lane_ack;

  // Descending scan so the lowest finished lane ends up selected
  always_comb begin
    pick_tag = '0;
    pick_res = '0;
    for (int i = `DIV_LANES - 1; i >= 0; i--) begin
      if (lane_done[i]) begin
        pick_tag = lane_tag_out[i];
        pick_res = lane_result[i];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_q <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PW'(`DIV_QDEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (q_pop) rd_ptr <= (rd_ptr == PW'(`DIV_QDEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      // Push and pop together leave the count unchanged
      count_q <= count_q + 3'(push) - 3'(q_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      tag_mem[wr_ptr] <= pick_tag;
      res_mem[wr_ptr] <= pick_res;
    end
  end

  assign q_valid  = (count_q != '0);
  assign q_count  = count_q;
  assign q_tag    = tag_mem[rd_ptr];
  assign q_result = res_mem[rd_ptr];

endmodule

`default_nettype wire

/* hw/div_config.svh */
`ifndef DIV_CONFIG_SVH
`define DIV_CONFIG_SVH

// Operand and result width
`define DIV_XLEN 32

// Division lanes running in parallel, 2 or 8 also work
`define DIV_LANES 4

// Launch sequence tag width
`define DIV_TAG_W 8

// Result queue entries
`define DIV_QDEPTH 4

// APB byte address width
`define DIV_AW 5

`endif

/* hw/div_dispatch.sv */
`default_nettype none
`timescale 1ns/1ns

`include "div_config.svh"

module div_dispatch (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [`DIV_AW-1:0]    paddr,
  input  logic [`DIV_XLEN-1:0]  pwdata,
  output logic [`DIV_XLEN-1:0]  prdata,
  output logic                  pready,
  output logic                  pslverr,
  input  logic [`DIV_LANES-1:0] lane_free,
  output logic [`DIV_LANES-1:0] lane_start,
  output logic [`DIV_XLEN-1:0]  lane_rs1,
  output logic [`DIV_XLEN-1:0]  lane_rs2,
  output div_pkg::div_op_e      lane_op,
  output logic [`DIV_TAG_W-1:0] lane_tag,
  input  logic                  q_valid,
  input  logic [2:0]            q_count,
  input  logic [`DIV_TAG_W-1:0] q_tag,
  input  logic [`DIV_XLEN-1:0]  q_result,
  output logic                  q_pop
);

  logic [`DIV_XLEN-1:0]  rs1_q;
  logic [`DIV_XLEN-1:0]  rs2_q;
  logic [`DIV_TAG_W-1:0] tag_q;
  logic                  access;
  logic                  cmd_wr;
  logic                  op_ok;
  logic                  any_free;
  logic                  launch;
  logic                  res_rd;
  logic [`DIV_XLEN-1:0]  status;

  // APB access phase
  assign access   = psel && penable;
  assign cmd_wr   = access && pwrite && (paddr == div_pkg::REG_CMD);
  assign res_rd   = access && !pwrite && (paddr == div_pkg::REG_RESULT);
  // Valid opcodes are 4 to 7
  assign op_ok    = pwdata[2];
  assign any_free = |lane_free;
  assign launch   = cmd_wr && op_ok && any_free;

  // Valid CMD waits for a lane, everything else has no wait state
  assign pready  = access && !(cmd_wr && op_ok && !any_free);
  assign pslverr = access && ((cmd_wr && !op_ok) || (res_rd && !q_valid));

  // Lowest free lane, isolated by two's complement
  assign lane_start = launch ? (lane_free & -lane_free) : '0;
  assign lane_rs1   = rs1_q;
  assign lane_rs2   = rs2_q;
  assign lane_op    = div_pkg::div_op_e'(pwdata[2:0]);
  assign lane_tag   = tag_q;
  assign q_pop      = res_rd && q_valid;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rs1_q <= '0;
      rs2_q <= '0;
      tag_q <= '0;
    end else begin
      if (access && pwrite && paddr == div_pkg::REG_RS1) rs1_q <= pwdata;
      if (access && pwrite && paddr == div_pkg::REG_RS2) rs2_q <= pwdata;
      // Tag counter wraps naturally
      if (launch) tag_q <= tag_q + 1'b1;
    end
  end

  always_comb begin
    status = '0;
    status[0] = q_valid;
    status[1] = ~|lane_free;
    status[4:2] = q_count;
    // Head tag reads 0 while the queue is empty
    status[8 +: `DIV_TAG_W] = q_valid ? q_tag : '0;
    status[16 +: `DIV_TAG_W] = tag_q;
  end

  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      case (paddr)
        div_pkg::REG_RS1:    prdata = rs1_q;
        div_pkg::REG_RS2:    prdata = rs2_q;
        div_pkg::REG_STATUS: prdata = status;
        div_pkg::REG_RESULT: prdata = q_valid ? q_result : '0;
        default:             prdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/div_lane.sv */
`default_nettype none
`timescale 1ns/1ns

`include "div_config.svh"

module div_lane (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  start,
  input  logic [`DIV_XLEN-1:0]  rs1,
  input  logic [`DIV_XLEN-1:0]  rs2,
  input  div_pkg::div_op_e      op,
  input  logic [`DIV_TAG_W-1:0] tag_in,
  input  logic                  ack,
  output logic                  free,
  output logic                  done,
  output logic [`DIV_XLEN-1:0]  result,
  output logic [`DIV_TAG_W-1:0] tag_out
);

  div_pkg::lane_state_e  state_q;
  div_pkg::div_op_e      op_q;
  logic [`DIV_TAG_W-1:0] tag_q;
  logic                  rs1_neg_q;
  logic                  rs2_neg_q;
  logic [`DIV_XLEN-1:0]  rs1_q;
  logic [`DIV_XLEN-1:0]  result_q;
  logic [`DIV_XLEN-1:0]  dividend_abs;
  logic [`DIV_XLEN-1:0]  divisor_abs;
  logic                  signed_q;
  logic                  core_busy;
  logic                  core_done;
  logic                  core_zero;
  logic [`DIV_XLEN-1:0]  core_quo;
  logic [`DIV_XLEN-1:0]  core_rem;
  logic [`DIV_XLEN-1:0]  res_sel;

  // Magnitudes only for signed ops, the core is unsigned
  assign dividend_abs = (!op[0] && rs1[`DIV_XLEN-1]) ? -rs1 : rs1;
  assign divisor_abs  = (!op[0] && rs2[`DIV_XLEN-1]) ? -rs2 : rs2;

  divu_core u_core (
    .clk      (clk),
    .arst_n   (arst_n),
    .start    (start),
    .dividend (dividend_abs),
    .divisor  (divisor_abs),
    .busy     (core_busy),
    .done     (core_done),
    .div_zero (core_zero),
    .quotient (core_quo),
    .remainder(core_rem)
  );

  assign signed_q = !op_q[0];

  always_comb begin
    if (core_zero) begin
      // Zero divisor: quotient all ones, remainder is the dividend
      res_sel = op_q[1] ? rs1_q : '1;
    end else if (op_q[1]) begin
      // Remainder follows the dividend sign
      res_sel = (signed_q && rs1_neg_q) ? -core_rem : core_rem;
    end else begin
      res_sel = (signed_q && (rs1_neg_q ^ rs2_neg_q)) ? -core_quo : core_quo;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= div_pkg::IDLE;
    end else begin
      case (state_q)
        div_pkg::IDLE: if (start) state_q <= div_pkg::RUN;
        div_pkg::RUN:  if (core_done) state_q <= div_pkg::HOLD;
        div_pkg::HOLD: if (ack) state_q <= div_pkg::IDLE;
        default:       state_q <= div_pkg::IDLE;
      endcase
    end
  end

  // Command fields captured at launch, result captured at finish
  always_ff @(posedge clk) begin
    if (start) begin
      op_q      <= op;
      tag_q     <= tag_in;
      rs1_neg_q <= rs1[`DIV_XLEN-1];
      rs2_neg_q <= rs2[`DIV_XLEN-1];
      rs1_q     <= rs1;
    end
    if (state_q == div_pkg::RUN && core_done) begin
      result_q <= res_sel;
    end
  end

  // Core must be idle too before a new launch
  assign free    = (state_q == div_pkg::IDLE) && !core_busy;
  assign done    = (state_q == div_pkg::HOLD);
  assign result  = result_q;
  assign tag_out = tag_q;

endmodule

`default_nettype wire

/* hw/div_pkg.sv */
`default_nettype none

`include "div_config.svh"

package div_pkg;

  // Values follow the M-extension funct3 field
  // Bit 0 clear selects signed, bit 1 set selects remainder
  typedef enum logic [2:0] {
    OP_DIV  = 3'd4,
    OP_DIVU = 3'd5,
    OP_REM  = 3'd6,
    OP_REMU = 3'd7
  } div_op_e;

  // HOLD keeps the result until the collector takes it
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RUN  = 2'd1,
    HOLD = 2'd2
  } lane_state_e;

  // Byte offsets of the register words
  typedef enum logic [`DIV_AW-1:0] {
    REG_RS1    = 'h00,
    REG_RS2    = 'h04,
    REG_CMD    = 'h08,
    REG_STATUS = 'h0c,
    REG_RESULT = 'h10
  } div_reg_e;

endpackage

`default_nettype wire

/* hw/div_top.sv */
`default_nettype none
`timescale 1ns/1ns

`include "div_config.svh"

module div_top (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [`DIV_AW-1:0]   paddr,
  input  logic [`DIV_XLEN-1:0] pwdata,
  output logic [`DIV_XLEN-1:0] prdata,
  output logic                 pready,
  output logic                 pslverr
);

  logic [`DIV_LANES-1:0]                 lane_start;
  logic [`DIV_LANES-1:0]                 lane_free;
  logic [`DIV_LANES-1:0]                 lane_done;
  logic [`DIV_LANES-1:0]                 lane_ack;
  logic [`DIV_XLEN-1:0]                  lane_rs1;
  logic [`DIV_XLEN-1:0]                  lane_rs2;
  div_pkg::div_op_e                      lane_op;
  logic [`DIV_TAG_W-1:0]                 lane_tag;
  logic [`DIV_LANES-1:0][`DIV_XLEN-1:0]  lane_result;
  logic [`DIV_LANES-1:0][`DIV_TAG_W-1:0] lane_tag_out;
  logic                                  q_valid;
  logic                                  q_pop;
  logic [2:0]                            q_count;
  logic [`DIV_TAG_W-1:0]                 q_tag;
  logic [`DIV_XLEN-1:0]                  q_result;

  // APB front end and launcher
  div_dispatch u_dispatch (
    .clk       (clk),
    .arst_n    (arst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .lane_free (lane_free),
    .lane_start(lane_start),
    .lane_rs1  (lane_rs1),
    .lane_rs2  (lane_rs2),
    .lane_op   (lane_op),
    .lane_tag  (lane_tag),
    .q_valid   (q_valid),
    .q_count   (q_count),
    .q_tag     (q_tag),
    .q_result  (q_result),
    .q_pop     (q_pop)
  );

  // Operand buses are shared, only the start bit is per lane
  for (genvar i = 0; i < `DIV_LANES; i++) begin : g_lane
    div_lane u_lane (
      .clk    (clk),
      .arst_n (arst_n),
      .start  (lane_start[i]),
      .rs1    (lane_rs1),
      .rs2    (lane_rs2),
      .op     (lane_op),
      .tag_in (lane_tag),
      .ack    (lane_ack[i]),
      .free   (lane_free[i]),
      .done   (lane_done[i]),
      .result (lane_result[i]),
      .tag_out(lane_tag_out[i])
    );
  end

  // Drains finished lanes into the result queue
  div_collect u_collect (
    .clk         (clk),
    .arst_n      (arst_n),
    .lane_done   (lane_done),
    .lane_result (lane_result),
    .lane_tag_out(lane_tag_out),
    .lane_ack    (lane_ack),
    .q_pop       (q_pop),
    .q_valid     (q_valid),
    .q_count     (q_count),
    .q_tag       (q_tag),
    .q_result    (q_result)
  );

endmodule

`default_nettype wire

/* hw/divu_core.sv */
`default_nettype none
`timescale 1ns/1ns

`include "div_config.svh"

module divu_core (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 start,
  input  logic [`DIV_XLEN-1:0] dividend,
  input  logic [`DIV_XLEN-1:0] divisor,
  output logic                 busy,
  output logic                 done,
  output logic                 div_zero,
  output logic [`DIV_XLEN-1:0] quotient,
  output logic [`DIV_XLEN-1:0] remainder
);

  // Counts completed steps, needs room for XLEN itself
  localparam int SW = $clog2(`DIV_XLEN) + 1;

  logic [SW-1:0]        step_q;
  logic                 busy_q;
  logic                 done_q;
  logic                 zero_q;
  // Dividend shifts out at the top while quotient bits enter at the bottom
  logic [`DIV_XLEN-1:0] quo_q;
  logic [`DIV_XLEN-1:0] rem_q;
  logic [`DIV_XLEN-1:0] dvs_q;
  logic [`DIV_XLEN-1:0] quo_in;
  logic [`DIV_XLEN-1:0] rem_in;
  logic [`DIV_XLEN-1:0] dvs_in;
  logic [`DIV_XLEN:0]   rem_shift;
  logic [`DIV_XLEN:0]   rem_diff;
  logic                 q_bit;

  // First step runs straight off the inputs in the start cycle
  assign quo_in = start ? dividend : quo_q;
  assign rem_in = start ? '0 : rem_q;
  assign dvs_in = start ? divisor : dvs_q;

  // Shift in next dividend bit, trial subtract
  assign rem_shift = {rem_in, quo_in[`DIV_XLEN-1]};
  assign rem_diff  = rem_shift - {1'b0, dvs_in};
  // No borrow means the divisor fits
  assign q_bit     = ~rem_diff[`DIV_XLEN];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      step_q <= '0;
      busy_q <= 1'b0;
      done_q <= 1'b0;
      zero_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start) begin
        zero_q <= (divisor == '0);
        if (divisor == '0) begin
          // Nothing to iterate, report next cycle
          done_q <= 1'b1;
        end else begin
          busy_q <= 1'b1;
          step_q <= SW'(1);
        end
      end else if (busy_q) begin
        step_q <= step_q + 1'b1;
        if (step_q == SW'(`DIV_XLEN - 1)) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start || busy_q) begin
      quo_q <= {quo_in[`DIV_XLEN-2:0], q_bit};
      // Restore on borrow
      rem_q <= q_bit ? rem_diff[`DIV_XLEN-1:0] : rem_shift[`DIV_XLEN-1:0];
    end
    if (start) begin
      dvs_q <= divisor;
    end
  end

  assign busy      = busy_q;
  assign done      = done_q;
  assign div_zero  = zero_q;
  assign quotient  = quo_q;
  assign remainder = rem_q;

endmodule

`default_nettype wire

/* sources.f */
+incdir+hw
hw/div_pkg.sv
hw/divu_core.sv
hw/div_lane.sv
hw/div_dispatch.sv
hw/div_collect.sv
hw/div_top.sv
test/div_tb.sv

/* test/div_tb.sv */
`default_nettype none
`timescale 1ns/1ns

`include "div_config.svh"

module div_tb;

  // Operations issued over all tests rounded up
  localparam int NUM_OPS = 56;
  // Per-operation budget plus reset and margin
  localparam int LIMIT_CYC = NUM_OPS * 200 + 2000;

  logic                  clk;
  logic                  arst_n;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [`DIV_AW-1:0]    paddr;
  logic [`DIV_XLEN-1:0]  pwdata;
  logic [`DIV_XLEN-1:0]  prdata;
  logic                  pready;
  logic                  pslverr;
  logic [31:0]           lfsr_q;
  // Expected result per launch tag
  logic [`DIV_XLEN-1:0]  exp_res [256];
  logic [`DIV_TAG_W-1:0] next_tag;
  logic [`DIV_XLEN-1:0]  cur_a;
  logic [`DIV_XLEN-1:0]  cur_b;
  int                    errors;
  int                    checks;
  int                    last_waits;

  div_top UUT (
    .clk    (clk),
    .arst_n (arst_n),
    .psel   (psel),
    .penable(penable),
    .pwrite (pwrite),
    .paddr  (paddr),
    .pwdata (pwdata),
    .prdata (prdata),
    .pready (pready),
    .pslverr(pslverr)
  );

  always #4 clk = ~clk;

  // Galois form with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic rand_word(output logic [`DIV_XLEN-1:0] w);
    w = '0;
    for (int i = 0; i < `DIV_XLEN; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      w = {w[`DIV_XLEN-2:0], lfsr_q[0]};
    end
  endtask

  // RISC-V M-extension division rules
  function automatic logic [`DIV_XLEN-1:0] ref_div(input div_pkg::div_op_e op,
                                                   input logic [`DIV_XLEN-1:0] a,
                                                   input logic [`DIV_XLEN-1:0] b);
    logic signed [`DIV_XLEN-1:0] sa;
    logic signed [`DIV_XLEN-1:0] sb;
    logic                        ovf;
    sa = a;
    sb = b;
    // Most negative over minus one
    ovf = (a == {1'b1, {(`DIV_XLEN-1){1'b0}}}) && (b == '1);
    if (b == '0) begin
      ref_div = (op == div_pkg::OP_DIV || op == div_pkg::OP_DIVU) ? '1 : a;
    end else if (op == div_pkg::OP_DIVU) begin
      ref_div = a / b;
    end else if (op == div_pkg::OP_REMU) begin
      ref_div = a % b;
    end else if (ovf) begin
      ref_div = (op == div_pkg::OP_DIV) ? a : '0;
    end else if (op == div_pkg::OP_DIV) begin
      ref_div = sa / sb;
    end else begin
      ref_div = sa % sb;
    end
  endfunction

  // Setup cycle, access cycle, then wait for pready sampled at the falling edge
  task automatic apb_xfer(input logic wr, input logic [`DIV_AW-1:0] addr,
                          input logic [`DIV_XLEN-1:0] wdata,
                          output logic [`DIV_XLEN-1:0] rdata, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    last_waits = 0;
    @(negedge clk);
    while (!pready) begin
      last_waits++;
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [`DIV_AW-1:0] addr, input logic [`DIV_XLEN-1:0] data,
                           output logic err);
    logic [`DIV_XLEN-1:0] unused;
    apb_xfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [`DIV_AW-1:0] addr, output logic [`DIV_XLEN-1:0] data,
                          output logic err);
    apb_xfer(1'b0, addr, '0, data, err);
  endtask

  task automatic check_val(input string name, input logic [`DIV_XLEN-1:0] exp,
                           input logic [`DIV_XLEN-1:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    checks++;
    assert (cond) else begin
      errors++;
      $display("%s", msg);
    end
  endtask

  task automatic set_operands(input logic [`DIV_XLEN-1:0] a, input logic [`DIV_XLEN-1:0] b);
    logic err;
    apb_write(div_pkg::REG_RS1, a, err);
    apb_write(div_pkg::REG_RS2, b, err);
    cur_a = a;
    cur_b = b;
  endtask

  // Tag of a launch is the count of launches before it
  task automatic issue_cmd(input div_pkg::div_op_e op);
    logic err;
    apb_write(div_pkg::REG_CMD, `DIV_XLEN'(op), err);
    check_true(!err, "CMD write with a valid opcode returned a slave error");
    exp_res[next_tag] = ref_div(op, cur_a, cur_b);
    next_tag++;
  endtask

  // Poll STATUS until a result waits, then read and pop it
  task automatic collect_one(input string name, output logic [`DIV_TAG_W-1:0] tag);
    logic [`DIV_XLEN-1:0] st;
    logic [`DIV_XLEN-1:0] res;
    logic                 err;
    st = '0;
    while (!st[0]) apb_read(div_pkg::REG_STATUS, st, err);
    tag = st[15:8];
    apb_read(div_pkg::REG_RESULT, res, err);
    check_true(!err, "RESULT read with a result waiting returned a slave error");
    check_val(name, exp_res[tag], res);
  endtask

  task automatic run_one(input string name, input div_pkg::div_op_e op,
                         input logic [`DIV_XLEN-1:0] a, input logic [`DIV_XLEN-1:0] b);
    logic [`DIV_TAG_W-1:0] want;
    logic [`DIV_TAG_W-1:0] got;
    want = next_tag;
    set_operands(a, b);
    issue_cmd(op);
    collect_one(name, got);
    check_val({name, "_tag"}, `DIV_XLEN'(want), `DIV_XLEN'(got));
  endtask

  task automatic test_reset();
    logic [`DIV_XLEN-1:0] d;
    logic                 err;
    apb_read(div_pkg::REG_STATUS, d, err);
    check_val("reset_status", '0, d);
    apb_read(div_pkg::REG_RESULT, d, err);
    check_true(err, "RESULT read on an empty queue gave no slave error");
    check_val("reset_result", '0, d);
  endtask

  task automatic test_unsigned();
    logic [`DIV_XLEN-1:0] a;
    logic [`DIV_XLEN-1:0] b;
    for (int i = 0; i < 20; i++) begin
      rand_word(a);
      rand_word(b);
      // Shorter divisors give wider quotients
      run_one("unsigned", i[0] ? div_pkg::OP_REMU : div_pkg::OP_DIVU, a, b >> (i % 24));
    end
  endtask

  task automatic test_signed();
    logic [`DIV_XLEN-1:0] a;
    logic [`DIV_XLEN-1:0] b;
    for (int i = 0; i < 10; i++) begin
      rand_word(a);
      rand_word(b);
      // Arithmetic shift keeps the divisor sign
      run_one("signed", i[0] ? div_pkg::OP_REM : div_pkg::OP_DIV, a, $signed(b) >>> (i % 20));
    end
    run_one("overflow_div", div_pkg::OP_DIV, 32'h8000_0000, 32'hffff_ffff);
    run_one("overflow_rem", div_pkg::OP_REM, 32'h8000_0000, 32'hffff_ffff);
    run_one("neg_pos_div", div_pkg::OP_DIV, -32'sd100, 32'd7);
    run_one("neg_pos_rem", div_pkg::OP_REM, -32'sd100, 32'd7);
    run_one("pos_neg_div", div_pkg::OP_DIV, 32'd100, -32'sd7);
    run_one("pos_neg_rem", div_pkg::OP_REM, 32'd100, -32'sd7);
  endtask

  task automatic test_div_zero();
    logic [`DIV_XLEN-1:0] a;
    rand_word(a);
    run_one("zero_div", div_pkg::OP_DIV, a, '0);
    run_one("zero_divu", div_pkg::OP_DIVU, a, '0);
    run_one("zero_rem", div_pkg::OP_REM, a, '0);
    run_one("zero_remu", div_pkg::OP_REMU, a, '0);
  endtask

  task automatic test_concurrency();
    logic [`DIV_XLEN-1:0]  a;
    logic [`DIV_XLEN-1:0]  st;
    logic [`DIV_TAG_W-1:0] tag;
    logic [`DIV_TAG_W-1:0] zero_tag;
    logic                  err;
    rand_word(a);
    set_operands(a, 32'hffff_fff9);
    // Back to back CMDs fill every lane
    for (int i = 0; i < `DIV_LANES; i++) issue_cmd(div_pkg::div_op_e'(3'(4 + (i % 4))));
    apb_read(div_pkg::REG_STATUS, st, err);
    check_true(st[1], "STATUS shows a free lane with every lane running");
    issue_cmd(div_pkg::OP_DIVU);
    check_true(last_waits > 0, "extra CMD completed while every lane was busy");
    apb_read(div_pkg::REG_STATUS, st, err);
    check_true(st[0], "extra CMD completed before any result was collected");
    for (int i = 0; i <= `DIV_LANES; i++) collect_one("concurrent", tag);
    // Zero divisor launched last overtakes the long ones
    set_operands(a, 32'd5);
    issue_cmd(div_pkg::OP_DIVU);
    issue_cmd(div_pkg::OP_REMU);
    set_operands(a, '0);
    zero_tag = next_tag;
    issue_cmd(div_pkg::OP_DIV);
    collect_one("zero_first", tag);
    check_val("zero_first_tag", `DIV_XLEN'(zero_tag), `DIV_XLEN'(tag));
    collect_one("long_after", tag);
    collect_one("long_after", tag);
  endtask

  // Queue is drained and every lane idle, so STATUS holds only the next tag
  task automatic test_bad_opcode();
    logic [`DIV_XLEN-1:0] st;
    logic                 err;
    for (int k = 0; k < 4; k++) begin
      apb_write(div_pkg::REG_CMD, `DIV_XLEN'(k), err);
      check_true(err, "CMD write with an invalid opcode gave no slave error");
      apb_read(div_pkg::REG_STATUS, st, err);
      check_val("bad_opcode_status", `DIV_XLEN'(next_tag) << 16, st);
    end
  endtask

  initial begin
    clk     = 1'b0;
    arst_n  = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    lfsr_q  = 32'h66d2_7f73;
    errors  = 0;
    checks  = 0;
    next_tag = '0;
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;
    test_reset();
    test_unsigned();
    test_signed();
    test_div_zero();
    test_concurrency();
    test_bad_opcode();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Hang guard
  initial begin
    repeat (LIMIT_CYC) @(posedge clk);
    $display("Watchdog timeout, tests did not finish within %0d cycles", LIMIT_CYC);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire
